// ==== Makefile ====
# Verilator build and run for the chroma-key tracker
VERILATOR ?= verilator
TOP       ?= tb_bruce_tracker
FILELIST  ?= bruce_tracker.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the testbench printed the pass line
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bruce_tracker.f ====
source/bruce_pkg.sv
source/delay_line.sv
source/green_mask.sv
source/majority_filter.sv
source/region_tracker.sv
source/overlay_mux.sv
source/bruce_tracker_top.sv
testbench/bruce_tracker_props.sv
testbench/tb_bruce_tracker.sv

// ==== source/bruce_pkg.sv ====
/*
 * Chroma-key tracker shared definitions
 * Widths, green thresholds, overlay colours, video structs and enums
 */
package bruce_pkg;

	//==========================================================================
	// Widths and thresholds
	//==========================================================================
	localparam int COORD_W  = 10;
	localparam int CHROMA_W = 8;
	localparam int COUNT_W  = 19;

	// A pixel is green when both chroma values sit strictly below these
	localparam logic [CHROMA_W-1:0] CB_GREEN_MAX = 8'd124;
	localparam logic [CHROMA_W-1:0] CR_GREEN_MAX = 8'd120;

	// Box is only drawn above this many pixels
	localparam int MIN_PIXEL_COUNT = 25;

	// Horizontal majority window
	localparam int FILTER_TAPS  = 5;
	localparam int FILTER_VOTES = 3;
	localparam int FILTER_SUM_W = $clog2(FILTER_TAPS + 1);

	// Input pixel to output pixel, in cycles
	localparam int PIPE_LATENCY = 3;

	//==========================================================================
	// Video types
	//==========================================================================
	typedef struct packed {
		logic [CHROMA_W-1:0] red;
		logic [CHROMA_W-1:0] green;
		logic [CHROMA_W-1:0] blue;
	} rgb_t;

	localparam rgb_t COLOR_MASK = '{red: 8'hFF, green: 8'h00, blue: 8'hFF};
	localparam rgb_t COLOR_BOX  = '{red: 8'hFF, green: 8'h00, blue: 8'h00};

	// Incoming video with chroma attached
	typedef struct packed {
		logic [COORD_W-1:0]  x;
		logic [COORD_W-1:0]  y;
		rgb_t                rgb;
		logic [CHROMA_W-1:0] cb;
		logic [CHROMA_W-1:0] cr;
		logic                blank_n;
		logic                vs;
	} pixel_t;

	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		rgb_t               rgb;
		logic               blank_n;
		logic               vs;
	} video_t;

	typedef struct packed {
		logic [COORD_W-1:0] min_x;
		logic [COORD_W-1:0] max_x;
		logic [COORD_W-1:0] min_y;
		logic [COORD_W-1:0] max_y;
		logic [COUNT_W-1:0] count;
	} box_t;

	//==========================================================================
	// Enums
	//==========================================================================
	typedef enum logic [1:0] {
		MODE_PASS = 2'd0,
		MODE_BOX  = 2'd1,
		MODE_MASK = 2'd2
	} overlay_mode_e;

	typedef enum logic {
		TRACK_EMPTY,
		TRACK_FOUND
	} track_state_e;

endpackage

// ==== source/bruce_tracker_top.sv ====
/*
 * Chroma-key tracker top level
 * Green mask, majority filter, region tracker and overlay on one clock
 */
module bruce_tracker_top
	import bruce_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  pixel_t        pixel_in,
	input  overlay_mode_e mode,
	output video_t        video_out,
	output box_t          box
);

	video_t video_in;
	video_t video_d2;
	logic   green;
	logic   blank_d1;
	logic   filtered;

	// Video fields without chroma
	assign video_in = '{x: pixel_in.x, y: pixel_in.y, rgb: pixel_in.rgb,
		blank_n: pixel_in.blank_n, vs: pixel_in.vs};

	green_mask u_green_mask (
		.clk     (clk),
		.reset   (reset),
		.cb      (pixel_in.cb),
		.cr      (pixel_in.cr),
		.blank_n (pixel_in.blank_n),
		.green   (green)
	);

	// Blank follows the green flag into the filter
	delay_line #(.WIDTH(1), .DEPTH(PIPE_LATENCY - 2)) u_blank_delay (
		.clk      (clk),
		.reset    (reset),
		.data_in  (pixel_in.blank_n),
		.data_out (blank_d1)
	);

	majority_filter u_majority_filter (
		.clk      (clk),
		.reset    (reset),
		.green    (green),
		.blank_n  (blank_d1),
		.filtered (filtered)
	);

	// Video lines up with the filtered flag
	delay_line #(.WIDTH($bits(video_t)), .DEPTH(PIPE_LATENCY - 1)) u_video_delay (
		.clk      (clk),
		.reset    (reset),
		.data_in  (video_in),
		.data_out (video_d2)
	);

	region_tracker u_region_tracker (
		.clk      (clk),
		.reset    (reset),
		.filtered (filtered),
		.video    (video_d2),
		.box      (box)
	);

	overlay_mux u_overlay_mux (
		.clk       (clk),
		.reset     (reset),
		.video     (video_d2),
		.filtered  (filtered),
		.box       (box),
		.mode      (mode),
		.video_out (video_out)
	);

endmodule

// ==== source/delay_line.sv ====
/*
 * Delay line
 * Shifts a video field through DEPTH cleared-on-reset registers
 */
module delay_line #(
	parameter int WIDTH = 1,
	parameter int DEPTH = 1
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] data_out
);

	logic [WIDTH-1:0] stage [DEPTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= data_in;
			// Remaining stages just follow their neighbour
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign data_out = stage[DEPTH-1];

endmodule

// ==== source/green_mask.sv ====
/*
 * Green mask
 * Registered chroma threshold test, one flag per active pixel
 */
module green_mask
	import bruce_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic [CHROMA_W-1:0] cb,
	input  logic [CHROMA_W-1:0] cr,
	input  logic                blank_n,
	output logic                green
);

	logic below_cb;
	logic below_cr;

	// Strict compare on both chroma axes
	assign below_cb = cb < CB_GREEN_MAX;
	assign below_cr = cr < CR_GREEN_MAX;

	always_ff @(posedge clk) begin
		if (reset) begin
			green <= 1'b0;
		end else begin
			// Blanked pixels never flag
			green <= blank_n && below_cb && below_cr;
		end
	end

endmodule

// ==== source/majority_filter.sv ====
/*
 * Majority filter
 * Five-tap horizontal vote over the green flags of one active run,
 * window cleared while the line is blanked
 */
module majority_filter
	import bruce_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic green,
	input  logic blank_n,
	output logic filtered
);

	logic [FILTER_TAPS-2:0]  history;
	logic [FILTER_TAPS-1:0]  window;
	logic [FILTER_SUM_W-1:0] votes;

	// Current flag plus its four predecessors
	assign window = {history, green};

	always_comb begin
		votes = '0;
		for (int i = 0; i < FILTER_TAPS; i++) begin
			votes = votes + FILTER_SUM_W'(window[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			history  <= '0;
			filtered <= 1'b0;
		end else begin
			// Flush the window between runs so pixels before a run count as 0
			if (!blank_n) begin
				history <= '0;
			end else begin
				history <= window[FILTER_TAPS-2:0];
			end
			filtered <= blank_n && (votes >= FILTER_SUM_W'(FILTER_VOTES));
		end
	end

endmodule

// ==== source/overlay_mux.sv ====
/*
 * Overlay mux
 * Picks the output colour per display mode and registers the video
 */
module overlay_mux
	import bruce_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  video_t        video,
	input  logic          filtered,
	input  box_t          box,
	input  overlay_mode_e mode,
	output video_t        video_out
);

	rgb_t color;
	logic in_x;
	logic in_y;
	logic on_border;
	logic box_valid;

	always_comb begin
		in_x      = (video.x >= box.min_x) && (video.x <= box.max_x);
		in_y      = (video.y >= box.min_y) && (video.y <= box.max_y);
		// Left/right columns or top/bottom rows of the box
		on_border = (((video.x == box.min_x) || (video.x == box.max_x)) && in_y) ||
			(((video.y == box.min_y) || (video.y == box.max_y)) && in_x);
		box_valid = box.count > COUNT_W'(MIN_PIXEL_COUNT);

		color = video.rgb;
		if (video.blank_n) begin
			case (mode)
				MODE_MASK: begin
					if (filtered) begin
						color = COLOR_MASK;
					end
				end
				MODE_BOX: begin
					if (box_valid && on_border) begin
						color = COLOR_BOX;
					end
				end
				// Pass, and the unused code 3
				default: color = video.rgb;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			video_out <= '0;
		end else begin
			video_out <= '{x: video.x, y: video.y, rgb: color,
				blank_n: video.blank_n, vs: video.vs};
		end
	end

endmodule

// ==== source/region_tracker.sv ====
/*
 * Region tracker
 * Bounding box and pixel count of the filtered pixels in a frame,
 * published on the falling edge of vertical sync
 */
module region_tracker
	import bruce_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   filtered,
	input  video_t video,
	output box_t   box
);

	track_state_e state;
	box_t         acc;
	logic         vs_prev;
	logic         vs_fall;

	// vs is active low, so the frame ends when it drops
	assign vs_fall = vs_prev && !video.vs;

	//==========================================================================
	// Frame state and published box
	//==========================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= TRACK_EMPTY;
			vs_prev <= 1'b0;
			box     <= '0;
		end else begin
			vs_prev <= video.vs;
			if (vs_fall) begin
				// Empty frame reports an all-zero box
				box   <= (state == TRACK_FOUND) ? acc : '0;
				state <= TRACK_EMPTY;
			end else if (filtered) begin
				state <= TRACK_FOUND;
			end
		end
	end

	//==========================================================================
	// Running extremes and count
	//==========================================================================
	always_ff @(posedge clk) begin
		if (filtered && !vs_fall) begin
			if (state == TRACK_EMPTY) begin
				// First pixel seeds all four extremes
				acc.min_x <= video.x;
				acc.max_x <= video.x;
				acc.min_y <= video.y;
				acc.max_y <= video.y;
				acc.count <= COUNT_W'(1);
			end else begin
				if (video.x < acc.min_x) begin
					acc.min_x <= video.x;
				end
				if (video.x > acc.max_x) begin
					acc.max_x <= video.x;
				end
				if (video.y < acc.min_y) begin
					acc.min_y <= video.y;
				end
				if (video.y > acc.max_y) begin
					acc.max_y <= video.y;
				end
				// Saturate rather than wrap
				if (acc.count != '1) begin
					acc.count <= acc.count + 1'b1;
				end
			end
		end
	end

endmodule

// ==== testbench/bruce_tracker_props.sv ====
/*
 * Tracker output properties
 * Reset state, video field latency and box update timing
 */
module bruce_tracker_props
	import bruce_pkg::*;
(
	input logic   clk,
	input logic   reset,
	input pixel_t pixel_in,
	input video_t video_out,
	input box_t   box
);
	timeunit 1ns;
	timeprecision 100ps;

	// Cycles since reset was released, saturating at 4
	logic [2:0] settled;

	always_ff @(posedge clk) begin
		if (reset) begin
			settled <= '0;
		end else if (settled != 3'd4) begin
			settled <= settled + 3'd1;
		end
	end

	a_reset_clear: assert property (@(posedge clk) reset |=> (video_out == '0 && box == '0))
		else $error("video_out or box not cleared by reset");

	// Pipeline still holds cleared stages
	a_reset_hold: assert property (@(posedge clk) (!reset && settled < 3'd3) |-> video_out == '0)
		else $error("video_out not zero in the first cycles after reset");

	a_field_latency: assert property (@(posedge clk) disable iff (reset)
		settled >= 3'd3 |->
		{video_out.x, video_out.y, video_out.blank_n, video_out.vs} ==
		$past({pixel_in.x, pixel_in.y, pixel_in.blank_n, pixel_in.vs}, PIPE_LATENCY))
		else $error("video_out fields do not match the input three cycles earlier");

	// vs is active low, so a frame ends on its falling edge
	a_box_on_vs_fall: assert property (@(posedge clk) disable iff (reset)
		(settled == 3'd4 && !$stable(box)) |->
		($past(pixel_in.vs, PIPE_LATENCY) == 1'b0 && $past(pixel_in.vs, PIPE_LATENCY + 1) == 1'b1))
		else $error("box changed without a vs falling edge");

endmodule

bind bruce_tracker_top bruce_tracker_props u_props (
	.clk       (clk),
	.reset     (reset),
	.pixel_in  (pixel_in),
	.video_out (video_out),
	.box       (box)
);

// ==== testbench/tb_bruce_tracker.sv ====
/*
 * Chroma-key tracker testbench
 * Directed frames through the DUT, checked against a reference model
 */
module tb_bruce_tracker
	import bruce_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;
	localparam int SEED         = 43192;
	localparam int ACTIVE_W     = 16;
	localparam int HBLANK       = 3;
	localparam int FRAME_H      = 8;
	localparam int VSYNC_LEN    = 4;
	localparam int VBACK_LEN    = 2;
	localparam int RUN_LEN      = 5;
	localparam int LINE_CYCLES  = ACTIVE_W + HBLANK;
	localparam int FRAME_CYCLES = FRAME_H * LINE_CYCLES + VSYNC_LEN + VBACK_LEN;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 6 * FRAME_CYCLES + 4 * (RUN_LEN + HBLANK)
		+ PIPE_LATENCY;
	// Green rectangle of the tracking frame
	localparam int RECT_X0 = 3;
	localparam int RECT_X1 = 9;
	localparam int RECT_Y0 = 2;
	localparam int RECT_Y1 = 6;
	localparam logic [CHROMA_W-1:0] CHROMA_GREEN = 8'd100;
	localparam logic [CHROMA_W-1:0] CHROMA_OTHER = 8'd200;

	logic          clk = 1'b0;
	logic          reset;
	pixel_t        pixel_in;
	overlay_mode_e mode;
	video_t        video_out;
	box_t          box;

	logic [ACTIVE_W-1:0] frame_mask [FRAME_H];
	video_t exp_video [$];
	box_t   exp_box [$];
	int     checks = 0;
	int     errors = 0;

	// Reference model state
	logic [FILTER_TAPS-2:0] m_hist = '0;
	logic m_vs_prev = 1'b0;
	logic m_found = 1'b0;
	box_t m_acc = '0;
	box_t m_box = '0;

	bruce_tracker_top uut (
		.clk       (clk),
		.reset     (reset),
		.pixel_in  (pixel_in),
		.mode      (mode),
		.video_out (video_out),
		.box       (box)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//==========================================================================
	// Compare tasks
	//==========================================================================
	task automatic check_video(input video_t actual, input video_t expected, input string name);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0d ns: %s is %h, expected %h",
				$time, name, actual, expected);
		end
	endtask

	task automatic check_box(input box_t actual, input box_t expected, input string name);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0d ns: %s is %h, expected %h",
				$time, name, actual, expected);
		end
	endtask

	//==========================================================================
	// Reference model, one call per pixel
	//==========================================================================
	task automatic model_pixel(input pixel_t p);
		logic   g;
		logic   filt;
		logic   on_col;
		logic   on_row;
		video_t e;
		g      = p.blank_n && (p.cb < CB_GREEN_MAX) && (p.cr < CR_GREEN_MAX);
		filt   = p.blank_n && ($countones({m_hist, g}) >= FILTER_VOTES);
		m_hist = p.blank_n ? {m_hist[FILTER_TAPS-3:0], g} : '0;
		e      = '{x: p.x, y: p.y, rgb: p.rgb, blank_n: p.blank_n, vs: p.vs};
		// Border of the box published by the previous frame
		on_col = (p.x == m_box.min_x || p.x == m_box.max_x) && p.y >= m_box.min_y
			&& p.y <= m_box.max_y;
		on_row = (p.y == m_box.min_y || p.y == m_box.max_y) && p.x >= m_box.min_x
			&& p.x <= m_box.max_x;
		if (p.blank_n && mode == MODE_MASK && filt) begin
			e.rgb = COLOR_MASK;
		end
		if (p.blank_n && mode == MODE_BOX && m_box.count > COUNT_W'(MIN_PIXEL_COUNT)
				&& (on_col || on_row)) begin
			e.rgb = COLOR_BOX;
		end
		// Frame ends on the vs falling edge and that pixel starts the next frame empty
		if (m_vs_prev && !p.vs) begin
			m_box   = m_found ? m_acc : '0;
			m_found = 1'b0;
		end else if (filt) begin
			if (!m_found) begin
				m_acc = '{min_x: p.x, max_x: p.x, min_y: p.y, max_y: p.y, count: COUNT_W'(1)};
			end else begin
				m_acc.min_x = (p.x < m_acc.min_x) ? p.x : m_acc.min_x;
				m_acc.max_x = (p.x > m_acc.max_x) ? p.x : m_acc.max_x;
				m_acc.min_y = (p.y < m_acc.min_y) ? p.y : m_acc.min_y;
				m_acc.max_y = (p.y > m_acc.max_y) ? p.y : m_acc.max_y;
				if (m_acc.count != '1) begin
					m_acc.count = m_acc.count + 1'b1;
				end
			end
			m_found = 1'b1;
		end
		m_vs_prev = p.vs;
		exp_video.push_back(e);
		exp_box.push_back(m_box);
	endtask

	//==========================================================================
	// Stimulus
	//==========================================================================
	task automatic drive_pixel(input pixel_t p);
		video_t ev;
		box_t   eb;
		@(negedge clk);
		// Output now belongs to the pixel driven three cycles ago
		if (exp_video.size() == PIPE_LATENCY) begin
			ev = exp_video.pop_front();
			eb = exp_box.pop_front();
			check_video(video_out, ev, "video_out");
			check_box(box, eb, "box");
		end
		pixel_in = p;
		model_pixel(p);
	endtask

	task automatic send_pixel(input int x, input int y, input logic blank_n, input logic vs,
			input logic [CHROMA_W-1:0] cb, input logic [CHROMA_W-1:0] cr);
		pixel_t p;
		p.x         = COORD_W'(x);
		p.y         = COORD_W'(y);
		p.rgb.red   = CHROMA_W'($urandom);
		p.rgb.green = CHROMA_W'($urandom);
		p.rgb.blue  = CHROMA_W'($urandom);
		p.cb        = cb;
		p.cr        = cr;
		p.blank_n   = blank_n;
		p.vs        = vs;
		drive_pixel(p);
	endtask

	// Active lines from frame_mask, then vertical sync and back porch
	task automatic send_frame(input bit random_chroma);
		logic [CHROMA_W-1:0] cb;
		logic [CHROMA_W-1:0] cr;
		for (int y = 0; y < FRAME_H; y++) begin
			for (int x = 0; x < LINE_CYCLES; x++) begin
				if (random_chroma) begin
					cb = CHROMA_W'($urandom);
					cr = CHROMA_W'($urandom);
				end else if (x < ACTIVE_W && frame_mask[y][x]) begin
					cb = CHROMA_GREEN;
					cr = CHROMA_GREEN;
				end else begin
					cb = CHROMA_OTHER;
					cr = CHROMA_OTHER;
				end
				send_pixel(x, y, x < ACTIVE_W, 1'b1, cb, cr);
			end
		end
		for (int i = 0; i < VSYNC_LEN + VBACK_LEN; i++) begin
			send_pixel(i, FRAME_H, 1'b0, i >= VSYNC_LEN, CHROMA_OTHER, CHROMA_OTHER);
		end
	endtask

	//==========================================================================
	// Directed tests
	//==========================================================================
	task automatic test_reset_pass();
		check_video(video_out, '0, "video_out");
		check_box(box, '0, "box");
		mode = MODE_PASS;
		send_frame(1'b1);
	endtask

	// Runs just inside and just outside each threshold
	task automatic test_green_threshold();
		logic [CHROMA_W-1:0] cb_list [4];
		logic [CHROMA_W-1:0] cr_list [4];
		cb_list = '{CB_GREEN_MAX - 8'd1, CB_GREEN_MAX, CB_GREEN_MAX - 8'd1, 8'd0};
		cr_list = '{CR_GREEN_MAX - 8'd1, CR_GREEN_MAX - 8'd1, CR_GREEN_MAX, 8'd0};
		mode = MODE_MASK;
		for (int i = 0; i < 4; i++) begin
			for (int x = 0; x < RUN_LEN; x++) begin
				send_pixel(x, i, 1'b1, 1'b1, cb_list[i], cr_list[i]);
			end
			// Green chroma while blanked
			for (int x = 0; x < HBLANK; x++) begin
				send_pixel(RUN_LEN + x, i, 1'b0, 1'b1, 8'd0, 8'd0);
			end
		end
	endtask

	task automatic test_majority();
		frame_mask = '{16'h0001, 16'h0006, 16'h0038, 16'h07C0,
			16'h0DB6, 16'h5555, 16'h7BDE, 16'h0000};
		send_frame(1'b0);
	endtask

	task automatic test_region();
		box_t expected;
		for (int y = 0; y < FRAME_H; y++) begin
			for (int x = 0; x < ACTIVE_W; x++) begin
				frame_mask[y][x] = y >= RECT_Y0 && y <= RECT_Y1 && x >= RECT_X0 && x <= RECT_X1;
			end
		end
		send_frame(1'b0);
		// Filtered run starts at the third green pixel and trails two past the last
		expected.min_x = COORD_W'(RECT_X0 + FILTER_VOTES - 1);
		expected.max_x = COORD_W'(RECT_X1 + FILTER_TAPS - FILTER_VOTES);
		expected.min_y = COORD_W'(RECT_Y0);
		expected.max_y = COORD_W'(RECT_Y1);
		expected.count = COUNT_W'((RECT_Y1 - RECT_Y0 + 1) * (RECT_X1 - RECT_X0 + 1));
		check_box(box, expected, "box");
	endtask

	task automatic test_box_overlay();
		mode = MODE_BOX;
		frame_mask = '{default: '0};
		send_frame(1'b0);
		// Two rows of four filtered pixels, under the count threshold
		frame_mask[2] = 16'h0078;
		frame_mask[3] = 16'h0078;
		send_frame(1'b0);
		check_box(box, '{min_x: 10'd5, max_x: 10'd8, min_y: 10'd2, max_y: 10'd3, count: 19'd8},
			"box");
		frame_mask = '{default: '0};
		send_frame(1'b0);
	endtask

	initial begin
		void'($urandom(SEED));
		reset    = 1'b1;
		pixel_in = '0;
		mode     = MODE_PASS;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		test_reset_pass();
		test_green_threshold();
		test_majority();
		test_region();
		test_box_overlay();
		// Flush the pipeline so the last real pixels get compared
		for (int i = 0; i < PIPE_LATENCY; i++) begin
			send_pixel(i, 0, 1'b0, 1'b1, CHROMA_OTHER, CHROMA_OTHER);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(4 * TOTAL_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", 4 * TOTAL_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule
